//--- all.f
rtl/blink_pkg.sv
rtl/blink_bank_map.sv
rtl/blink_rtc.sv
rtl/blink_int_ctrl.sv
rtl/blink_io_read.sv
rtl/blink.sv
dv/blink_checker.sv
dv/tb_blink.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_blink, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/Vtb_blink: all.f rtl/*.sv dv/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_blink -f all.f

test: obj_dir/Vtb_blink
	./obj_dir/Vtb_blink > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_blink.sv
module tb_blink;
  import blink_pkg::*;

  localparam tick_t TICK_DIV = 16'd20;  // Short ticks for simulation

  logic        mck, rst;
  cpu_addr_t   ca;
  io_data_t    cdi, cdo;
  logic        crd_n, mrq_n, ior_n, cm1_n, hlt_n;
  logic [63:0] kbmat;
  phys_addr_t  ma;
  logic        ipce_n, irce_n, se1_n, se2_n, se3_n, roe_n, wrb_n;
  logic        intb_n, nmib_n, pm1, rout_n;
  integer      seed;
  int          pulses;

  blink #(.tick_div(TICK_DIV)) dut (.*);

  blink_checker #(.tick_div(TICK_DIV)) chk (
    .mck, .rst, .ca, .cdi, .crd_n, .mrq_n, .ior_n, .kbmat, .ma,
    .ipce_n, .irce_n, .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n, .cdo, .intb_n,
    .nmib_n, .rout_n
  );

  initial begin
    mck = 1'b0;
    forever #5 mck = ~mck;
  end

  task automatic io_write(input io_port_t port, input io_data_t data);
    @(posedge mck);
    ca <= {8'h00, port};
    cdi <= data;
    crd_n <= 1'b1;
    ior_n <= 1'b0;
    @(posedge mck);  // Register takes the byte here
    ior_n <= 1'b1;
  endtask

  task automatic io_read(input io_port_t port, input logic [7:0] rows);
    @(posedge mck);
    ca <= {rows, port};
    crd_n <= 1'b0;
    ior_n <= 1'b0;
    repeat (2) @(posedge mck);  // Checker samples cdo in between
    ior_n <= 1'b1;
    crd_n <= 1'b1;
  endtask

  task automatic mem_cycle(input cpu_addr_t addr, input logic rd);
    @(posedge mck);
    ca <= addr;
    crd_n <= !rd;
    mrq_n <= 1'b0;
    @(posedge mck);
    mrq_n <= 1'b1;
    crd_n <= 1'b1;
  endtask

  task automatic acknowledge();
    @(posedge mck);
    ca <= 16'h00FF;  // Unmapped port so the read buffer keeps its byte
    cm1_n <= 1'b0;
    crd_n <= 1'b0;
    ior_n <= 1'b0;
    repeat (2) @(posedge mck);
    ior_n <= 1'b1;
    cm1_n <= 1'b1;
    crd_n <= 1'b1;
  endtask

  task automatic wait_intb(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (intb_n !== level && n < limit) begin
      @(negedge mck);
      n++;
    end
    if (intb_n !== level)
      chk.note_fail({"timeout waiting for ", what});
  endtask

  task automatic count_pm1(input int cycles, output int cnt);
    cnt = 0;
    repeat (cycles) begin
      @(negedge mck);
      if (pm1)
        cnt++;
    end
  endtask

  initial begin
    seed = 9;
    rst = 1'b1;
    ca = '0;
    cdi = '0;
    crd_n = 1'b1;
    mrq_n = 1'b1;
    ior_n = 1'b1;
    cm1_n = 1'b1;
    hlt_n = 1'b1;
    kbmat = '0;
    repeat (16) @(posedge mck);
    rst <= 1'b0;

    chk.start_test("address mapping");
    for (int round = 0; round < 4; round++) begin
      for (int s = 0; s < 4; s++)
        io_write(8'hD0 + s, $random(seed));
      io_write(PORT_COM, {5'b00000, round[0], 2'b00});  // Toggle RAMS
      for (int i = 0; i < 25; i++)
        mem_cycle($random(seed), $random(seed));
    end
    chk.end_test();

    chk.start_test("keyboard read");
    for (int i = 0; i < 30; i++) begin
      @(posedge mck);
      kbmat <= {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
      io_read(PORT_KBD, $random(seed));
    end
    chk.end_test();

    chk.start_test("rtc counting");
    io_write(PORT_COM, 8'h00);
    repeat (TICK_DIV * 207) @(posedge mck);  // Past one 5 ms wrap
    for (int p = 0; p < 5; p++)
      io_read(8'hD0 + p, 8'hFF);
    chk.end_test();

    chk.start_test("timer status");
    for (int i = 0; i < 40; i++) begin
      repeat ($unsigned($random(seed)) % 30) @(posedge mck);
      if ($random(seed) & 1)
        io_write(PORT_TACK, $random(seed));
      else
        io_read(PORT_TSTA, 8'hFF);
    end
    io_write(PORT_COM, 8'h10);  // Hold the RTC
    for (int p = 0; p < 5; p++)
      io_read(8'hD0 + p, 8'hFF);
    io_write(PORT_COM, 8'h00);
    chk.end_test();

    chk.start_test("interrupt path");
    io_write(PORT_TACK, 8'h07);
    io_write(PORT_TMK, 8'h01);
    io_write(PORT_INT, 8'h03);  // GINT and TIME
    wait_intb(1'b0, TICK_DIV * 4, "intb_n to fall");
    io_read(PORT_STA, 8'hFF);
    repeat (10) begin
      @(negedge mck);
      if (intb_n)
        chk.note_fail("intb_n rose before the acknowledge");
    end
    acknowledge();
    wait_intb(1'b1, 10, "intb_n to rise after the acknowledge");
    io_write(PORT_INT, 8'h02);  // GINT off
    io_write(PORT_TACK, 8'h07);
    repeat (TICK_DIV * 3) begin
      @(negedge mck);
      if (!intb_n)
        chk.note_fail("intb_n fell with GINT clear");
    end
    io_read(PORT_STA, 8'hFF);
    chk.end_test();

    chk.start_test("snooze");
    @(posedge mck);
    hlt_n <= 1'b0;
    repeat (4) @(posedge mck);
    count_pm1(15, pulses);
    if (pulses != 0)
      chk.note_fail("pm1 kept running after HALT");
    io_write(PORT_TACK, 8'h07);
    io_write(PORT_INT, 8'h03);
    wait_intb(1'b0, TICK_DIV * 4, "intb_n to wake the CPU");
    count_pm1(10, pulses);
    if (pulses < 2)
      chk.note_fail("pm1 did not restart after the interrupt");
    @(posedge mck);
    hlt_n <= 1'b1;
    acknowledge();
    wait_intb(1'b1, 10, "intb_n to rise after the wake up");
    chk.end_test();

    @(posedge mck);
    chk.summary();
    if (chk.errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- dv/blink_checker.sv
module blink_checker #(
  parameter blink_pkg::tick_t tick_div = blink_pkg::TICK_DIV_DEFAULT
) (
  input logic                  mck,
  input logic                  rst,
  input blink_pkg::cpu_addr_t  ca,
  input blink_pkg::io_data_t   cdi,
  input logic                  crd_n,
  input logic                  mrq_n,
  input logic                  ior_n,
  input logic [63:0]           kbmat,
  input blink_pkg::phys_addr_t ma,
  input logic                  ipce_n,
  input logic                  irce_n,
  input logic                  se1_n,
  input logic                  se2_n,
  input logic                  se3_n,
  input logic                  roe_n,
  input logic                  wrb_n,
  input blink_pkg::io_data_t   cdo,
  input logic                  intb_n,
  input logic                  nmib_n,
  input logic                  rout_n
);
  import blink_pkg::*;

  int       errors = 0;
  int       test_errors = 0;
  int       tests = 0;
  string    test_name = "";
  bank_t    sr_m [4];           // Model copies of the bus registers
  io_data_t com_m;
  logic [2:0] int1_m, tmk_m, tsta_m;
  tick_t    tck_m;              // Own prescaler
  tim0_t    tim0_m;
  tim1_t    tim1_m;
  timm_t    timm_m;
  io_data_t buf_m;              // Expected read buffer
  logic     ior_q;

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    if (test_errors == 0)
      $display("test %s: ok", test_name);
    else
      $display("test %s: %0d errors", test_name, test_errors);
  endtask

  task automatic note_fail(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, sig, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic summary();
    $display("tests run %0d, errors %0d", tests, errors);
  endtask

  // Top two CPU bits pick the segment
  function automatic phys_addr_t exp_ma(input cpu_addr_t a);
    case (a[15:14])
      2'd3: return {sr_m[3], a[13:0]};
      2'd2: return {sr_m[2], a[13:0]};
      2'd1: return {sr_m[1], a[13:0]};
      default: begin
        if (a[13])
          return {sr_m[0], 1'b1, a[12:0]};  // Upper half of the sr0 bank
        return {(com_m[2] ? 8'h20 : 8'h00), a[13:0]};
      end
    endcase
  endfunction

  // Active low {ipce, irce, se1, se2, se3}
  function automatic logic [4:0] exp_ce(input phys_addr_t m);
    bank_t b;
    b = m[21:14];
    if (b >= 8'hC0)
      return 5'b11110;
    if (b >= 8'h80)
      return 5'b11101;
    if (b >= 8'h40)
      return 5'b11011;
    if (b[7:5] == 3'b000)
      return 5'b01111;  // Internal PROM
    if (b[7:5] == 3'b001)
      return 5'b10111;  // Internal RAM
    return 5'b11111;
  endfunction

  function automatic io_data_t exp_read(input cpu_addr_t a, input io_data_t old);
    io_data_t rows;
    logic     rtc_on, key_on;
    rows = 8'h00;
    for (int r = 0; r < 8; r++)
      if (a[8 + r] == 1'b0)
        rows |= kbmat[8 * r +: 8];
    rtc_on = (|(tsta_m & tmk_m)) && int1_m[1];
    key_on = int1_m[2] && (kbmat != 64'd0);
    case (a[7:0])
      8'hB1: return {5'd0, key_on, rtc_on, int1_m[0] && (rtc_on || key_on)};
      8'hB2: return ~rows;                  // Low means pressed
      8'hB5: return {5'd0, tsta_m};
      8'hD0: return tim0_m;
      8'hD1: return {2'b00, tim1_m};
      8'hD2: return timm_m[7:0];
      8'hD3: return timm_m[15:8];
      8'hD4: return {3'b000, timm_m[20:16]};
      default: return old;                  // Unmapped port
    endcase
  endfunction

  // Register and RTC model
  always @(posedge mck) begin
    logic wr, rd, tk, w0, w1;
    logic [2:0] clr;
    wr = !ior_n && crd_n;
    rd = !ior_n && !crd_n;
    if (rst) begin
      for (int i = 0; i < 4; i++)
        sr_m[i] <= '0;
      com_m <= '0;
      int1_m <= '0;
      tmk_m <= '0;
      tsta_m <= '0;
      tck_m <= '0;
      tim0_m <= '0;
      tim1_m <= '0;
      timm_m <= '0;
      buf_m <= '0;
      ior_q <= 1'b1;
    end else begin
      ior_q <= ior_n;
      if (wr) begin
        case (ca[7:0])
          8'hB0: com_m <= cdi;
          8'hB1: int1_m <= cdi[2:0];
          8'hD0: sr_m[0] <= cdi;
          8'hD1: sr_m[1] <= cdi;
          8'hD2: sr_m[2] <= cdi;
          8'hD3: sr_m[3] <= cdi;
          default: ;
        endcase
      end
      if (wr && ior_q && ca[7:0] == 8'hB5)
        tmk_m <= cdi[2:0];
      tk = !com_m[4] && (tck_m == tick_div - 1);  // 5 ms tick
      w0 = tk && (tim0_m == 8'd199);
      w1 = w0 && (tim1_m == 6'd59);
      if (com_m[4]) begin
        tck_m <= '0;   // Hold clears everything
        tim0_m <= '0;
        tim1_m <= '0;
        timm_m <= '0;
      end else begin
        tck_m <= tk ? '0 : tck_m + 1;
        if (tk)
          tim0_m <= w0 ? '0 : tim0_m + 1;
        if (w0)
          tim1_m <= w1 ? '0 : tim1_m + 1;
        if (w1)
          timm_m <= timm_m + 1;
      end
      clr = (wr && ior_q && ca[7:0] == 8'hB4) ? cdi[2:0] : 3'b000;
      tsta_m <= (tsta_m & ~clr) | {w1, w0, tk};  // A set wins
      if (rd && ior_q)
        buf_m <= exp_read(ca, buf_m);
    end
  end

  // Compare away from the active edge
  always @(negedge mck) begin
    compare("rout_n", !rst, rout_n);   // CPU reset follows rst
    compare("nmib_n", 1'b1, nmib_n);   // No NMI source
    if (!rst) begin
      if (!mrq_n) begin
        compare("ma", exp_ma(ca), ma);
        compare("chip_enables", exp_ce(exp_ma(ca)), {ipce_n, irce_n, se1_n, se2_n, se3_n});
        compare("roe_n", crd_n, roe_n);
        compare("wrb_n", !crd_n, wrb_n);
      end else begin
        // No memory cycle, so nothing is selected
        compare("chip_enables", 5'b11111, {ipce_n, irce_n, se1_n, se2_n, se3_n});
        compare("roe_n", 1'b1, roe_n);
        compare("wrb_n", 1'b1, wrb_n);
      end
      if (!ior_n && !crd_n && !ior_q)
        compare("cdo", buf_m, cdo);
      if (!int1_m[0] && !intb_n)
        note_fail("intb_n went low while interrupts are globally disabled");
    end
  end

endmodule

//--- rtl/blink.sv
module blink #(
  parameter blink_pkg::tick_t tick_div = blink_pkg::TICK_DIV_DEFAULT
) (
  input  logic                  mck,
  input  logic                  rst,
  input  blink_pkg::cpu_addr_t  ca,
  input  blink_pkg::io_data_t   cdi,
  input  logic                  crd_n,
  input  logic                  mrq_n,
  input  logic                  ior_n,
  input  logic                  cm1_n,
  input  logic                  hlt_n,
  input  logic [63:0]           kbmat,
  output blink_pkg::phys_addr_t ma,
  output logic                  ipce_n,
  output logic                  irce_n,
  output logic                  se1_n,
  output logic                  se2_n,
  output logic                  se3_n,
  output logic                  roe_n,
  output logic                  wrb_n,
  output blink_pkg::io_data_t   cdo,
  output logic                  intb_n,
  output logic                  nmib_n,
  output logic                  pm1,
  output logic                  rout_n
);
  import blink_pkg::*;

  logic       com_rtc_hold;
  logic       rtc_int;
  logic [2:0] tsta;
  logic [2:0] int_en;
  tim0_t      tim0;
  tim1_t      tim1;
  timm_t      timm;

  assign nmib_n = 1'b1;  // No NMI source
  assign rout_n = ~rst;  // CPU reset

  blink_bank_map u_bank_map (
    .mck, .rst, .ca, .cdi, .ior_n, .crd_n, .mrq_n, .ma,
    .ipce_n, .irce_n, .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n,
    .com_rtc_hold
  );

  blink_rtc #(.tick_div(tick_div)) u_rtc (
    .mck, .rst, .com_rtc_hold, .ca, .cdi, .ior_n, .crd_n,
    .tim0, .tim1, .timm, .tsta, .rtc_int
  );

  blink_int_ctrl u_int_ctrl (
    .mck, .rst, .ca, .cdi, .ior_n, .crd_n, .cm1_n, .hlt_n,
    .rtc_int, .int_en, .intb_n, .pm1
  );

  blink_io_read u_io_read (
    .mck, .rst, .ca, .cdi, .ior_n, .crd_n, .kbmat, .tsta, .rtc_int,
    .int_en, .tim0, .tim1, .timm, .cdo
  );

endmodule

//--- rtl/blink_io_read.sv
module blink_io_read (
  input  logic                 mck,
  input  logic                 rst,
  input  blink_pkg::cpu_addr_t ca,
  input  blink_pkg::io_data_t  cdi,
  input  logic                 ior_n,
  input  logic                 crd_n,
  input  logic [63:0]          kbmat,
  input  logic [2:0]           tsta,
  input  logic                 rtc_int,
  input  logic [2:0]           int_en,
  input  blink_pkg::tim0_t     tim0,
  input  blink_pkg::tim1_t     tim1,
  input  blink_pkg::timm_t     timm,
  output blink_pkg::io_data_t  cdo
);
  import blink_pkg::*;

  io_data_t key_rows;  // OR of the selected rows
  io_data_t kbd;       // Low bit means pressed
  io_data_t sta;
  io_data_t rd_buf;
  logic     kbd_int;
  logic     rtc_sta;
  logic     ior_q;
  logic     rd_first;

  // A low address bit selects its row
  always_comb begin
    key_rows = '0;
    for (int r = 0; r < 8; r++) begin
      if (!ca[8 + r])
        key_rows = key_rows | kbmat[8 * r +: 8];
    end
    kbd = ~key_rows;
  end

  assign kbd_int = int_en[2] && (|kbmat);  // Any key down
  assign rtc_sta = rtc_int && int_en[1];
  // Bit 0 summarises the enabled sources under GINT
  assign sta = {5'b00000, kbd_int, rtc_sta, int_en[0] && (rtc_sta || kbd_int)};

  always_ff @(posedge mck) begin
    if (rst)
      ior_q <= 1'b1;
    else
      ior_q <= ior_n;
  end

  assign rd_first = !ior_n && !crd_n && ior_q;

  // Read buffer loads once per I/O cycle
  always_ff @(posedge mck) begin
    if (rst) begin
      rd_buf <= '0;
    end else if (rd_first) begin
      case (ca[7:0])
        PORT_STA:  rd_buf <= sta;
        PORT_KBD:  rd_buf <= kbd;
        PORT_TSTA: rd_buf <= {5'b00000, tsta};
        PORT_TIM0: rd_buf <= tim0;                  // 5 ms ticks
        PORT_TIM1: rd_buf <= {2'b00, tim1};         // Seconds
        PORT_TIM2: rd_buf <= timm[7:0];             // Minutes
        PORT_TIM3: rd_buf <= timm[15:8];
        PORT_TIM4: rd_buf <= {3'b000, timm[20:16]};
        default: ;                                  // Unmapped keeps old byte
      endcase
    end
  end

  assign cdo = ior_n ? cdi : rd_buf;

endmodule

//--- rtl/blink_int_ctrl.sv
module blink_int_ctrl (
  input  logic                 mck,
  input  logic                 rst,
  input  blink_pkg::cpu_addr_t ca,
  input  blink_pkg::io_data_t  cdi,
  input  logic                 ior_n,
  input  logic                 crd_n,
  input  logic                 cm1_n,
  input  logic                 hlt_n,
  input  logic                 rtc_int,
  output logic [2:0]           int_en,
  output logic                 intb_n,
  output logic                 pm1
);
  import blink_pkg::*;

  logic [2:0] int1;      // GINT, TIME and KEY enables
  logic       int1_wr;
  logic       gint_nxt;  // GINT as it stands after this edge
  logic       int_src;
  logic       src_q;
  logic       ack;       // IORQ with M1
  logic       ack_q;
  logic       set_req;
  logic       clr_req;
  logic [1:0] clk_cnt;   // Divide by three
  logic       z80_clk;
  logic       pm1s;      // Snooze latch
  logic       halt_req;
  logic       wake_req;

  assign int1_wr  = !ior_n && crd_n && (ca[7:0] == PORT_INT);
  assign gint_nxt = int1_wr ? cdi[0] : int1[0];

  always_ff @(posedge mck) begin
    if (rst)
      int1 <= '0;
    else if (int1_wr)
      int1 <= cdi[2:0];
  end

  assign int_en  = int1;
  assign int_src = rtc_int && int1[0] && int1[1];
  assign ack     = !ior_n && !cm1_n;

  // Edge detectors for set and acknowledge
  always_ff @(posedge mck) begin
    if (rst) begin
      src_q   <= 1'b0;
      ack_q   <= 1'b0;
      set_req <= 1'b0;
      clr_req <= 1'b0;
    end else begin
      src_q   <= int_src;
      ack_q   <= ack;
      set_req <= int_src && !src_q;  // Rising edge only
      clr_req <= ack && !ack_q;
    end
  end

  always_ff @(posedge mck) begin
    if (rst || !gint_nxt)
      intb_n <= 1'b1;      // GINT off releases INT
    else if (set_req)
      intb_n <= 1'b0;
    else if (clr_req)
      intb_n <= 1'b1;
  end

  // CPU clock
  always_ff @(posedge mck) begin
    if (rst) begin
      clk_cnt <= '0;
      z80_clk <= 1'b0;
    end else begin
      clk_cnt <= (clk_cnt == 2'd2) ? 2'd0 : clk_cnt + 2'd1;
      z80_clk <= (clk_cnt == 2'd2);
    end
  end

  // HALT stops the clock and INT wakes it
  always_ff @(posedge mck) begin
    if (rst) begin
      halt_req <= 1'b0;
      wake_req <= 1'b0;
      pm1s     <= 1'b1;
    end else begin
      halt_req <= !hlt_n && intb_n;
      wake_req <= !intb_n;
      if (wake_req)
        pm1s <= 1'b1;
      else if (halt_req)
        pm1s <= 1'b0;
    end
  end

  assign pm1 = pm1s && z80_clk;

  a_no_int_gint_off: assert property (@(posedge mck) disable iff (rst)
    !int1[0] |-> intb_n);

endmodule

//--- rtl/blink_rtc.sv
module blink_rtc #(
  parameter blink_pkg::tick_t tick_div = blink_pkg::TICK_DIV_DEFAULT
) (
  input  logic                 mck,
  input  logic                 rst,
  input  logic                 com_rtc_hold,
  input  blink_pkg::cpu_addr_t ca,
  input  blink_pkg::io_data_t  cdi,
  input  logic                 ior_n,
  input  logic                 crd_n,
  output blink_pkg::tim0_t     tim0,
  output blink_pkg::tim1_t     tim1,
  output blink_pkg::timm_t     timm,
  output logic [2:0]           tsta,
  output logic                 rtc_int
);
  import blink_pkg::*;

  tick_t      tck;        // Prescaler
  logic       tick;       // One mck cycle every 5 ms
  logic       wrap0;      // 5 ms counter wraps
  logic       wrap1;      // Seconds counter wraps
  logic [2:0] tmk;        // Timer mask
  logic [2:0] tsta_set;
  logic [2:0] tsta_clr;
  logic       ior_q;      // ior_n one cycle back
  logic       wr_first;   // First edge of an I/O write

  // I/O cycle start
  always_ff @(posedge mck) begin
    if (rst)
      ior_q <= 1'b1;
    else
      ior_q <= ior_n;
  end

  assign wr_first = !ior_n && crd_n && ior_q;

  assign tick  = !com_rtc_hold && (tck == tick_div - 16'd1);
  assign wrap0 = tick && (tim0 == TIM0_LAST);
  assign wrap1 = wrap0 && (tim1 == TIM1_LAST);

  // Prescaler and cascaded counters
  always_ff @(posedge mck) begin
    if (rst || com_rtc_hold) begin
      tck  <= '0;
      tim0 <= '0;
      tim1 <= '0;
      timm <= '0;
    end else begin
      tck <= tick ? '0 : tck + 16'd1;
      if (tick)
        tim0 <= wrap0 ? '0 : tim0 + 8'd1;
      if (wrap0)
        tim1 <= wrap1 ? '0 : tim1 + 6'd1;
      if (wrap1)
        timm <= timm + 21'd1;  // Free running minutes
    end
  end

  // Status bits
  assign tsta_set = {wrap1, wrap0, tick};
  assign tsta_clr = (wr_first && ca[7:0] == PORT_TACK) ? cdi[2:0] : 3'b000;

  always_ff @(posedge mck) begin
    if (rst)
      tsta <= '0;
    else
      tsta <= (tsta & ~tsta_clr) | tsta_set;  // Set beats clear
  end

  // Mask register
  always_ff @(posedge mck) begin
    if (rst)
      tmk <= '0;
    else if (wr_first && ca[7:0] == PORT_TMK)
      tmk <= cdi[2:0];
  end

  assign rtc_int = |(tsta & tmk);

  a_tim0_range: assert property (@(posedge mck) disable iff (rst)
    tim0 <= TIM0_LAST);

endmodule

//--- rtl/blink_bank_map.sv
module blink_bank_map (
  input  logic                   mck,
  input  logic                   rst,
  input  blink_pkg::cpu_addr_t   ca,
  input  blink_pkg::io_data_t    cdi,
  input  logic                   ior_n,
  input  logic                   crd_n,
  input  logic                   mrq_n,
  output blink_pkg::phys_addr_t  ma,
  output logic                   ipce_n,
  output logic                   irce_n,
  output logic                   se1_n,
  output logic                   se2_n,
  output logic                   se3_n,
  output logic                   roe_n,
  output logic                   wrb_n,
  output logic                   com_rtc_hold
);
  import blink_pkg::*;

  bank_t    sr0, sr1, sr2, sr3;
  io_data_t com;                 // Common control register
  logic     reg_wr;

  assign reg_wr = !ior_n && crd_n;

  // Segment and COM registers
  always_ff @(posedge mck) begin
    if (rst) begin
      sr0 <= '0;
      sr1 <= '0;
      sr2 <= '0;
      sr3 <= '0;
      com <= '0;
    end else if (reg_wr) begin
      case (ca[7:0])
        PORT_COM: com <= cdi;
        PORT_SR0: sr0 <= cdi;
        PORT_SR1: sr1 <= cdi;
        PORT_SR2: sr2 <= cdi;
        PORT_SR3: sr3 <= cdi;
        default: ;
      endcase
    end
  end

  assign com_rtc_hold = com[4];  // RESTIM

  // Logical to physical translation
  always_comb begin
    case (ca[15:14])
      2'b11: ma = {sr3, ca[13:0]};  // C000-FFFF
      2'b10: ma = {sr2, ca[13:0]};  // 8000-BFFF
      2'b01: ma = {sr1, ca[13:0]};  // 4000-7FFF
      default: begin
        if (ca[13])
          ma = {sr0, 1'b1, ca[12:0]};  // 2000-3FFF upper half of sr0
        else
          ma = {(com[2] ? RAMS_BANK : 8'h00), 1'b0, ca[12:0]};
      end
    endcase
  end

  // Chip enables from the top physical bits
  always_comb begin
    ipce_n = 1'b1;
    irce_n = 1'b1;
    se1_n  = 1'b1;
    se2_n  = 1'b1;
    se3_n  = 1'b1;
    if (!mrq_n) begin
      case (ma[21:20])
        2'b00: begin
          // Slot 0 splits into PROM and RAM
          ipce_n = (ma[21:19] != ROM_SELECT);
          irce_n = (ma[21:19] != RAM_SELECT);
        end
        2'b01:   se1_n = 1'b0;  // Banks 40-7F
        2'b10:   se2_n = 1'b0;  // Banks 80-BF
        default: se3_n = 1'b0;  // Banks C0-FF
      endcase
    end
  end

  assign roe_n = !(!mrq_n && !crd_n);  // Memory read
  assign wrb_n = !(!mrq_n && crd_n);   // Memory write

  a_one_ce: assert property (@(posedge mck) disable iff (rst)
    $onehot0(~{ipce_n, irce_n, se1_n, se2_n, se3_n}));

endmodule

//--- rtl/blink_pkg.sv
package blink_pkg;

  // Bus widths
  typedef logic [15:0] cpu_addr_t;   // Z80 logical address
  typedef logic [21:0] phys_addr_t;  // Bank in 21:14 and offset in 13:0
  typedef logic [7:0]  bank_t;       // Segment register value
  typedef logic [7:0]  io_data_t;
  typedef logic [7:0]  io_port_t;    // Low address byte of an I/O access

  // RTC widths
  typedef logic [15:0] tick_t;       // Prescaler count
  typedef logic [7:0]  tim0_t;       // 5 ms ticks
  typedef logic [5:0]  tim1_t;       // Seconds
  typedef logic [20:0] timm_t;       // Minutes

  // I/O ports
  localparam io_port_t PORT_COM  = 8'hB0;
  localparam io_port_t PORT_INT  = 8'hB1;  // Write side
  localparam io_port_t PORT_STA  = 8'hB1;  // Read side
  localparam io_port_t PORT_KBD  = 8'hB2;
  localparam io_port_t PORT_TACK = 8'hB4;  // Write only
  localparam io_port_t PORT_TSTA = 8'hB5;  // Read side
  localparam io_port_t PORT_TMK  = 8'hB5;  // Write side
  localparam io_port_t PORT_SR0  = 8'hD0;
  localparam io_port_t PORT_SR1  = 8'hD1;
  localparam io_port_t PORT_SR2  = 8'hD2;
  localparam io_port_t PORT_SR3  = 8'hD3;
  localparam io_port_t PORT_TIM0 = 8'hD0;
  localparam io_port_t PORT_TIM1 = 8'hD1;
  localparam io_port_t PORT_TIM2 = 8'hD2;
  localparam io_port_t PORT_TIM3 = 8'hD3;
  localparam io_port_t PORT_TIM4 = 8'hD4;

  // 5 ms at the 9.83 MHz master clock
  localparam tick_t TICK_DIV_DEFAULT = 16'd49152;

  // Counter wrap points
  localparam tim0_t TIM0_LAST = 8'd199;
  localparam tim1_t TIM1_LAST = 6'd59;

  // Bank for 0000-1FFF when RAMS is set
  localparam bank_t RAMS_BANK = 8'h20;

  // Top three physical address bits of slot 0
  localparam logic [2:0] ROM_SELECT = 3'b000;  // Internal PROM
  localparam logic [2:0] RAM_SELECT = 3'b001;  // Internal RAM

endpackage
